/* list.f */
sar_adc_pkg.sv
sar_sample_timer.sv
sar_bit_search.sv
sar_overs_accum.sv
sar_offset_trim.sv
sar_ctrl_fsm.sv
sar_adc_top.sv
tb_sar_adc.sv

/* sar_adc_patterns.txt */
# mode chnr stc overs vin comp_val offset
# mode 0 calibrate, 1 convert, 2 fast compare; offset is a signed code
0 0 0 0 0 0 5
1 0 0 0 1000 0 5
1 1 1 0 0 0 5
1 15 3 0 2047 0 5
1 7 2 1 512 0 5
1 3 1 2 1500 0 5
1 0 1 3 77 0 5
1 12 0 3 2040 0 5
2 5 0 0 700 699 5
2 9 1 0 700 900 5
2 2 3 0 2047 2047 5
0 0 0 0 0 0 -12
1 4 0 0 1234 0 -12
1 10 2 2 300 0 -12
2 6 0 0 100 95 -12
1 14 3 1 1800 0 -12
1 1 0 0 2047 0 -12
1 8 1 0 3 0 -12

/* sar_adc_pkg.sv */
`default_nettype none

package sar_adc_pkg;

  // conversion and channel widths
  localparam int CONV_BITS  = 11;
  localparam int N_CHANNELS = 16;

  typedef logic [CONV_BITS-1:0]  conv_code_t;
  typedef logic [3:0]            chnr_t;
  typedef logic [N_CHANNELS-1:0] ch_sel_t;
  typedef logic [13:0]           result_t;    // 11.3 averaged result
  typedef logic [1:0]            overs_cfg_t; // 2^cfg samples
  typedef logic [1:0]            stc_t;       // x1, x1/2, x2, x4
  typedef logic [7:0]            samp_cnt_t;

  // comparator offset calibration
  localparam int TRIM_BITS = 6;

  typedef logic signed [TRIM_BITS-1:0] trim_t;

  localparam logic [TRIM_BITS-1:0] CAL_ZERO = 6'd32; // cal_o code for zero trim
  localparam trim_t TRIM_MAX = 6'sd31;
  localparam trim_t TRIM_MIN = -6'sd31;

  localparam int         CAL_STEPS         = 32;
  localparam samp_cnt_t  CAL_SAMPLE_CYCLES = 8'd8;
  localparam conv_code_t MIDSCALE          = 11'd1024;

  // base sampling time per channel, 4 + 2n
  localparam samp_cnt_t SAMPLE_TABLE [N_CHANNELS] = '{
    8'd4,  8'd6,  8'd8,  8'd10, 8'd12, 8'd14, 8'd16, 8'd18,
    8'd20, 8'd22, 8'd24, 8'd26, 8'd28, 8'd30, 8'd32, 8'd34
  };

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CAL_SAMPLE,
    ST_CAL_COMP,
    ST_SAMPLE,
    ST_SEARCH,
    ST_COMPARE,
    ST_RESULT
  } fsm_state_t;

endpackage

`default_nettype wire

/* sar_adc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_adc_top
  import sar_adc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n_i,
  // conversion request
  input  logic                 start_valid_i,
  output logic                 start_ready_o,
  input  chnr_t                chnr_i,
  input  stc_t                 stc_i,
  input  overs_cfg_t           overs_cfg_i,
  input  logic                 comp_en_i,
  input  conv_code_t           comp_val_i,
  // result
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output result_t              result_o,
  // startup calibration
  input  logic                 sucal_i,
  output logic                 sucal_done_o,
  // analog side
  input  logic                 comp_i,
  output conv_code_t           dac_code_o,
  output logic [TRIM_BITS-1:0] cal_o,
  output logic                 ocs_o,
  output ch_sel_t              sample_ch_o
);

  logic       samp_load;
  logic       samp_expired;
  logic       search_start;
  logic       search_done;
  logic       acc_clear;
  logic       acc_add;
  logic       trim_step;
  logic       cal_mode;
  logic       comp_mode;
  overs_cfg_t overs_cfg;
  conv_code_t conv_code;
  trim_t      trim;

  sar_ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_valid_i  (start_valid_i),
    .start_ready_o  (start_ready_o),
    .chnr_i         (chnr_i),
    .overs_cfg_i    (overs_cfg_i),
    .comp_en_i      (comp_en_i),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .sucal_i        (sucal_i),
    .sucal_done_o   (sucal_done_o),
    .ocs_o          (ocs_o),
    .sample_ch_o    (sample_ch_o),
    .cal_o          (cal_o),
    .trim_i         (trim),
    .cal_mode_o     (cal_mode),
    .comp_mode_o    (comp_mode),
    .overs_cfg_o    (overs_cfg),
    .samp_load_o    (samp_load),
    .samp_expired_i (samp_expired),
    .search_start_o (search_start),
    .search_done_i  (search_done),
    .acc_clear_o    (acc_clear),
    .acc_add_o      (acc_add),
    .trim_step_o    (trim_step)
  );

  sar_sample_timer u_timer (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .load_i     (samp_load),
    .cal_mode_i (cal_mode),
    .chnr_i     (chnr_i),
    .stc_i      (stc_i),
    .expired_o  (samp_expired)
  );

  sar_bit_search u_search (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (search_start),
    .comp_mode_i (comp_mode),
    .cal_mode_i  (cal_mode),
    .comp_val_i  (comp_val_i),
    .comp_i      (comp_i),
    .dac_code_o  (dac_code_o),
    .done_o      (search_done),
    .code_o      (conv_code)
  );

  sar_overs_accum u_accum (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .clear_i     (acc_clear),
    .add_i       (acc_add),
    .code_i      (conv_code),
    .overs_cfg_i (overs_cfg),
    .result_o    (result_o)
  );

  sar_offset_trim u_trim (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .step_i  (trim_step),
    .comp_i  (comp_i),
    .trim_o  (trim)
  );

endmodule

`default_nettype wire

/* sar_bit_search.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_bit_search
  import sar_adc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  logic       comp_mode_i,
  input  logic       cal_mode_i,
  input  conv_code_t comp_val_i,
  input  logic       comp_i,
  output conv_code_t dac_code_o,
  output logic       done_o,
  output conv_code_t code_o
);

  conv_code_t trial_q;
  conv_code_t bit_q;    // one-hot, bit under test
  logic       busy_q;
  logic       single_q; // fast compare, one decision only

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      trial_q  <= '0;
      bit_q    <= '0;
      busy_q   <= 1'b0;
      single_q <= 1'b0;
      done_o   <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        busy_q   <= 1'b1;
        single_q <= comp_mode_i;
        bit_q    <= comp_mode_i ? '0 : conv_code_t'(1) << (CONV_BITS - 1);
        trial_q  <= comp_mode_i ? comp_val_i : conv_code_t'(1) << (CONV_BITS - 1);
      end
      else if (busy_q)
      begin
        if (single_q)
          trial_q <= {CONV_BITS{comp_i}};
        else
          // keep or drop the tested bit, then try the next one
          trial_q <= (trial_q & ~bit_q) | (comp_i ? bit_q : '0) | (bit_q >> 1);
        bit_q <= bit_q >> 1;
        if (single_q || bit_q[0])
        begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  assign dac_code_o = cal_mode_i ? MIDSCALE : trial_q;
  assign code_o     = trial_q;

endmodule

`default_nettype wire

/* sar_ctrl_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_ctrl_fsm
  import sar_adc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 start_valid_i,
  output logic                 start_ready_o,
  input  chnr_t                chnr_i,
  input  overs_cfg_t           overs_cfg_i,
  input  logic                 comp_en_i,
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  input  logic                 sucal_i,
  output logic                 sucal_done_o,
  output logic                 ocs_o,
  output ch_sel_t              sample_ch_o,
  output logic [TRIM_BITS-1:0] cal_o,
  input  trim_t                trim_i,
  output logic                 cal_mode_o,
  output logic                 comp_mode_o,
  output overs_cfg_t           overs_cfg_o,
  output logic                 samp_load_o,
  input  logic                 samp_expired_i,
  output logic                 search_start_o,
  input  logic                 search_done_i,
  output logic                 acc_clear_o,
  output logic                 acc_add_o,
  output logic                 trim_step_o
);

  fsm_state_t state_q;
  fsm_state_t state_d;

  logic                         cal_ok_q;     // startup cal ran at least once
  logic [$clog2(CAL_STEPS)-1:0] cal_step_q;
  logic [2:0]                   overs_left_q; // conversions still to do
  logic                         comp_en_q;
  overs_cfg_t                   overs_cfg_q;
  logic                         take_cal;
  logic                         take_conv;
  logic                         last_step;
  logic                         analog_phase;

  // sucal wins over a pending start
  assign take_cal      = (state_q == ST_IDLE) && sucal_i;
  assign start_ready_o = (state_q == ST_IDLE) && cal_ok_q && !sucal_i;
  assign take_conv     = start_valid_i && start_ready_o;
  assign last_step     = (int'(cal_step_q) == CAL_STEPS - 1);

  assign analog_phase = (state_q == ST_CAL_SAMPLE) || (state_q == ST_CAL_COMP) ||
                        (state_q == ST_SAMPLE) || (state_q == ST_SEARCH) ||
                        (state_q == ST_COMPARE);

  assign ocs_o          = (state_q == ST_SAMPLE) || (state_q == ST_CAL_SAMPLE);
  assign cal_o          = analog_phase ? CAL_ZERO + $unsigned(trim_i) : CAL_ZERO;
  assign result_valid_o = (state_q == ST_RESULT);
  assign cal_mode_o     = take_cal || (state_q == ST_CAL_SAMPLE) || (state_q == ST_CAL_COMP);
  assign comp_mode_o    = comp_en_q;
  assign overs_cfg_o    = overs_cfg_q;

  always_comb
  begin
    state_d        = state_q;
    samp_load_o    = 1'b0;
    search_start_o = 1'b0;
    acc_clear_o    = 1'b0;
    acc_add_o      = 1'b0;
    trim_step_o    = 1'b0;
    case (state_q)
      ST_IDLE :
      begin
        if (take_cal)
        begin
          samp_load_o = 1'b1;
          state_d     = ST_CAL_SAMPLE;
        end
        else if (take_conv)
        begin
          samp_load_o = 1'b1;
          acc_clear_o = 1'b1;
          state_d     = ST_SAMPLE;
        end
      end
      ST_CAL_SAMPLE :
      begin
        if (samp_expired_i)
          state_d = ST_CAL_COMP;
      end
      ST_CAL_COMP :
      begin
        trim_step_o = 1'b1; // comp_i gives the direction
        if (last_step)
          state_d = ST_IDLE;
        else
        begin
          samp_load_o = 1'b1;
          state_d     = ST_CAL_SAMPLE;
        end
      end
      ST_SAMPLE :
      begin
        if (samp_expired_i)
        begin
          search_start_o = 1'b1;
          state_d        = comp_en_q ? ST_COMPARE : ST_SEARCH;
        end
      end
      ST_SEARCH, ST_COMPARE :
      begin
        if (search_done_i)
        begin
          acc_add_o = 1'b1;
          if (overs_left_q != '0)
          begin
            samp_load_o = 1'b1; // next oversample right away
            state_d     = ST_SAMPLE;
          end
          else
            state_d = ST_RESULT;
        end
      end
      ST_RESULT :
      begin
        if (result_ready_i)
          state_d = ST_IDLE;
      end
      default : state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q      <= ST_IDLE;
      cal_ok_q     <= 1'b0;
      cal_step_q   <= '0;
      overs_left_q <= '0;
      comp_en_q    <= 1'b0;
      overs_cfg_q  <= '0;
      sample_ch_o  <= '0;
      sucal_done_o <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      sucal_done_o <= 1'b0;
      if (take_cal)
        cal_step_q <= '0;
      if (state_q == ST_CAL_COMP)
      begin
        cal_step_q <= cal_step_q + 1'b1;
        if (last_step)
        begin
          cal_ok_q     <= 1'b1;
          sucal_done_o <= 1'b1;
        end
      end
      if (take_conv)
      begin
        // a compare is always a single shot
        comp_en_q    <= comp_en_i;
        overs_cfg_q  <= comp_en_i ? '0 : overs_cfg_i;
        overs_left_q <= comp_en_i ? '0 : 3'((4'd1 << overs_cfg_i) - 4'd1);
        sample_ch_o  <= ch_sel_t'(1) << chnr_i;
      end
      if (acc_add_o && (overs_left_q != '0))
        overs_left_q <= overs_left_q - 3'd1;
      if ((state_q == ST_RESULT) && result_ready_i)
        sample_ch_o <= '0; // channel released with the result
    end
  end

endmodule

`default_nettype wire

/* sar_offset_trim.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_offset_trim
  import sar_adc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  step_i,
  input  logic  comp_i,
  output trim_t trim_o
);

  trim_t trim_d;

  // comparator high at midscale means offset too positive
  always_comb
  begin
    trim_d = trim_o;
    if (comp_i)
    begin
      if (trim_o != TRIM_MIN)
        trim_d = trim_o - 6'sd1;
    end
    else
    begin
      if (trim_o != TRIM_MAX)
        trim_d = trim_o + 6'sd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      trim_o <= '0;
    else if (step_i)
      trim_o <= trim_d; // one count per compare
  end

endmodule

`default_nettype wire

/* sar_overs_accum.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_overs_accum
  import sar_adc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       clear_i,
  input  logic       add_i,
  input  conv_code_t code_i,
  input  overs_cfg_t overs_cfg_i,
  output result_t    result_o
);

  result_t sum_q; // up to 8 x 2047

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      sum_q <= '0;
    else if (clear_i)
      sum_q <= '0;
    else if (add_i)
      sum_q <= sum_q + result_t'(code_i);
  end

  // sum of 2^cfg samples scaled to 11.3
  always_comb
  begin
    case (overs_cfg_i)
      2'd0    : result_o = sum_q << 3;
      2'd1    : result_o = sum_q << 2;
      2'd2    : result_o = sum_q << 1;
      default : result_o = sum_q;
    endcase
  end

endmodule

`default_nettype wire

/* sar_sample_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_sample_timer
  import sar_adc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  load_i,
  input  logic  cal_mode_i,
  input  chnr_t chnr_i,
  input  stc_t  stc_i,
  output logic  expired_o
);

  samp_cnt_t base;
  samp_cnt_t scaled;
  samp_cnt_t len;
  samp_cnt_t cnt_q;

  always_comb
  begin
    base = SAMPLE_TABLE[chnr_i];
    case (stc_i)
      2'd1    : scaled = base >> 1; // half
      2'd2    : scaled = base << 1;
      2'd3    : scaled = base << 2;
      default : scaled = base;
    endcase
    if (cal_mode_i)
      len = CAL_SAMPLE_CYCLES;
    else if (scaled == '0)
      len = 8'd1; // never shorter than one cycle
    else
      len = scaled;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else if (load_i)
      cnt_q <= len - 8'd1;
    else if (cnt_q != '0)
      cnt_q <= cnt_q - 8'd1;
  end

  assign expired_o = (cnt_q == '0); // last sample cycle

endmodule

`default_nettype wire

/* tb_sar_adc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sar_adc
  import sar_adc_pkg::*;
();

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 8;
  localparam int    WAIT_LIMIT   = 2000; // cycles per wait loop
  localparam int    MAX_STALL    = 6;
  localparam string PATTERN_FILE = "sar_adc_patterns.txt";

  logic                 clk;
  logic                 rst_n_i;
  logic                 start_valid_i;
  logic                 start_ready_o;
  chnr_t                chnr_i;
  stc_t                 stc_i;
  overs_cfg_t           overs_cfg_i;
  logic                 comp_en_i;
  conv_code_t           comp_val_i;
  logic                 result_valid_o;
  logic                 result_ready_i;
  result_t              result_o;
  logic                 sucal_i;
  logic                 sucal_done_o;
  logic                 comp_i;
  conv_code_t           dac_code_o;
  logic [TRIM_BITS-1:0] cal_o;
  logic                 ocs_o;
  ch_sel_t              sample_ch_o;

  int   errors           = 0;
  int   timeouts         = 0;
  int   tb_trim          = 0; // replayed trim, never read from the DUT
  int   offset           = 0;
  int   vin              = 0;
  int   done_pulses      = 0;
  int   cals_run         = 0;
  int   results_taken    = 0;
  int   results_expected = 0;
  logic cal_running      = 1'b0;
  logic aborted          = 1'b0;

  sar_adc_top uut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_valid_i  (start_valid_i),
    .start_ready_o  (start_ready_o),
    .chnr_i         (chnr_i),
    .stc_i          (stc_i),
    .overs_cfg_i    (overs_cfg_i),
    .comp_en_i      (comp_en_i),
    .comp_val_i     (comp_val_i),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .sucal_i        (sucal_i),
    .sucal_done_o   (sucal_done_o),
    .comp_i         (comp_i),
    .dac_code_o     (dac_code_o),
    .cal_o          (cal_o),
    .ocs_o          (ocs_o),
    .sample_ch_o    (sample_ch_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // result handshakes seen at the clock edge
  always @(posedge clk)
  begin
    if (rst_n_i && result_valid_o && result_ready_i)
      results_taken++;
  end

  // falling edge, then the comparator model
  task automatic next_cycle();
    @(negedge clk);
    if (cal_running)
      comp_i = (offset + tb_trim >= 0);
    else
      comp_i = (vin + offset + tb_trim >= int'(dac_code_o));
    if (sucal_done_o)
      done_pulses++;
  endtask

  task automatic compare_value(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timeouts++;
    aborted = 1'b1;
  endtask

  function automatic int expected_cal();
    return (int'(CAL_ZERO) + tb_trim) & 'h3f;
  endfunction

  task automatic run_calibration(input int off);
    int step;
    int high_cycles;
    int wait_cnt;
    offset      = off;
    cal_running = 1'b1;
    sucal_i     = 1'b1;
    cals_run++;
    for (step = 0; step < CAL_STEPS; step++)
    begin
      wait_cnt = 0;
      while (!ocs_o && !aborted)
      begin
        next_cycle();
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT)
          report_timeout("a calibration sample phase");
      end
      if (aborted)
        break;
      sucal_i     = 1'b0; // request already taken
      high_cycles = 0;
      while (ocs_o && !aborted)
      begin
        compare_value("cal_o", int'(cal_o), expected_cal());
        high_cycles++;
        next_cycle();
        if (high_cycles > WAIT_LIMIT)
          report_timeout("the end of a calibration sample phase");
      end
      if (aborted)
        break;
      compare_value("ocs_o cal high cycles", high_cycles, int'(CAL_SAMPLE_CYCLES));
      compare_value("dac_code_o", int'(dac_code_o), int'(MIDSCALE));
      // compare cycle, trim moves against the decision
      if (comp_i)
        tb_trim = (tb_trim > int'(TRIM_MIN)) ? tb_trim - 1 : tb_trim;
      else
        tb_trim = (tb_trim < int'(TRIM_MAX)) ? tb_trim + 1 : tb_trim;
    end
    wait_cnt = 0;
    while (done_pulses < cals_run && !aborted)
    begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT)
        report_timeout("sucal_done_o");
    end
    cal_running = 1'b0;
    next_cycle();
    compare_value("sucal_done_o", int'(sucal_done_o), 0); // one cycle only
  endtask

  task automatic run_conversion(input int mode, input int ch, input int stc, input int overs,
                                input int v, input int cv, input int off);
    int      s_len;
    int      x;
    int      exp_res;
    int      pulses_exp;
    int      pulses;
    int      run_len;
    int      wait_cnt;
    int      stall;
    logic    ocs_prev;
    result_t held;
    offset = off;
    vin    = v;
    s_len  = 4 + 2 * ch;
    case (stc)
      1 : s_len = s_len / 2;
      2 : s_len = s_len * 2;
      3 : s_len = s_len * 4;
      default : s_len = s_len;
    endcase
    if (s_len < 1)
      s_len = 1;
    x = v + off + tb_trim;
    if (mode == 2)
    begin
      exp_res    = (x >= cv) ? 2047 * 8 : 0;
      pulses_exp = 1;
    end
    else
    begin
      x          = (x < 0) ? 0 : ((x > 2047) ? 2047 : x);
      exp_res    = x * 8; // average of equal codes, 3 fraction bits
      pulses_exp = 1 << overs;
    end
    results_expected++;
    chnr_i        = chnr_t'(ch);
    stc_i         = stc_t'(stc);
    overs_cfg_i   = overs_cfg_t'(overs);
    comp_en_i     = (mode == 2);
    comp_val_i    = conv_code_t'(cv);
    start_valid_i = 1'b1;
    wait_cnt      = 0;
    while (!start_ready_o && !aborted)
    begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT)
        report_timeout("start_ready_o");
    end
    if (aborted)
      return;
    next_cycle(); // request taken on this edge
    start_valid_i = 1'b0;
    pulses        = 0;
    run_len       = 0;
    ocs_prev      = 1'b0;
    wait_cnt      = 0;
    while (!result_valid_o && !aborted)
    begin
      compare_value("cal_o", int'(cal_o), expected_cal()); // trimmed through sample and SAR
      if (ocs_o)
      begin
        if (!ocs_prev)
          pulses++;
        run_len++;
        compare_value("sample_ch_o", int'(sample_ch_o), 1 << ch);
      end
      else if (ocs_prev)
      begin
        compare_value("ocs_o high cycles", run_len, s_len);
        run_len = 0;
      end
      ocs_prev = ocs_o;
      next_cycle();
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT)
        report_timeout("result_valid_o");
    end
    if (aborted)
      return;
    compare_value("ocs_o pulses", pulses, pulses_exp);
    compare_value("result_o", int'(result_o), exp_res);
    compare_value("cal_o", int'(cal_o), int'(CAL_ZERO)); // no trim while the result waits
    held  = result_o;
    stall = int'($urandom % MAX_STALL);
    repeat (stall)
    begin
      next_cycle();
      compare_value("result_valid_o", int'(result_valid_o), 1);
      compare_value("result_o", int'(result_o), int'(held));
      compare_value("start_ready_o", int'(start_ready_o), 0);
    end
    result_ready_i = 1'b1;
    next_cycle();
    result_ready_i = 1'b0;
    compare_value("result_valid_o", int'(result_valid_o), 0); // delivered once
  endtask

  initial
  begin
    int    seed;
    int    fd;
    int    n;
    int    mode;
    int    ch;
    int    stc;
    int    overs;
    int    v;
    int    cv;
    int    off;
    string line;
    seed           = int'($urandom(16));
    rst_n_i        = 1'b0;
    start_valid_i  = 1'b0;
    chnr_i         = '0;
    stc_i          = '0;
    overs_cfg_i    = '0;
    comp_en_i      = 1'b0;
    comp_val_i     = '0;
    result_ready_i = 1'b0;
    sucal_i        = 1'b0;
    comp_i         = 1'b0;
    repeat (RESET_CYCLES) next_cycle();
    rst_n_i = 1'b1;
    next_cycle();
    compare_value("start_ready_o", int'(start_ready_o), 0); // no start before cal
    compare_value("result_valid_o", int'(result_valid_o), 0);
    compare_value("ocs_o", int'(ocs_o), 0);
    compare_value("sucal_done_o", int'(sucal_done_o), 0);
    compare_value("sample_ch_o", int'(sample_ch_o), 0);
    compare_value("cal_o", int'(cal_o), int'(CAL_ZERO));
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the pattern file %s", PATTERN_FILE);
      errors++;
    end
    else
    begin
      while (!$feof(fd) && !aborted)
      begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%d %d %d %d %d %d %d", mode, ch, stc, overs, v, cv, off);
          if (n == 7 && mode == 0)
            run_calibration(off);
          else if (n == 7)
            run_conversion(mode, ch, stc, overs, v, cv, off);
        end
      end
      $fclose(fd);
    end
    compare_value("results delivered", results_taken, results_expected);
    compare_value("sucal_done_o pulses", done_pulses, cals_run);
    $display("summary: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
